// File: include/tim_settings.svh
//============================
// widths, synchronizer depth and reset values of the timer
// configuration block, included by packages and RTL
//============================
`ifndef TIM_SETTINGS_SVH
`define TIM_SETTINGS_SVH

// bus and field widths
`define TIM_DATA_W 32
`define TIM_CNT_W 16
`define TIM_ENC_W 24
`define TIM_DTG_W 10

// flops in each pe_clk synchronizer
`define TIM_SYNC_STAGES 2

// reset values of the configuration fields
`define TIM_RST_PSC 'h2
`define TIM_RST_ARR 'h32
`define TIM_RST_DTG 'h5
`define TIM_RST_ENC_ARR 'h8000

`endif

// File: verilog/tim_apb_pkg.sv
//============================
// bus side of the timer register block
// register offsets, field positions and command bits
//============================
`default_nettype none

`include "tim_settings.svh"

package tim_apb_pkg;

	typedef logic [`TIM_DATA_W-1:0] apb_addr_t;

	localparam apb_addr_t TIM_OFS_CTRL = 'h00;
	localparam apb_addr_t TIM_OFS_CMD = 'h04;
	localparam apb_addr_t TIM_OFS_GEN_TB = 'h08;
	localparam apb_addr_t TIM_OFS_GEN_CC1 = 'h0C;
	localparam apb_addr_t TIM_OFS_GEN_LOCK = 'h10;
	localparam apb_addr_t TIM_OFS_ENC = 'h14;

	// field positions inside the data word
	localparam int CTRL_GEN_EN_BIT = 0;
	localparam int CTRL_ENC_EN_BIT = 1;
	localparam int CTRL_HW_UPD_BIT = 2;
	localparam int GEN_TB_PSC_LSB = 0;
	localparam int GEN_TB_ARR_LSB = 16;
	localparam int GEN_CC1_LSB = 0;
	localparam int GEN_OC1M_LSB = 16;
	localparam int LOCK_DTG_LSB = 0;
	localparam int LOCK_CC1E_BIT = 16;
	localparam int LOCK_CC1P_BIT = 17;
	localparam int LOCK_MOE1_BIT = 18;
	localparam int LOCK_BK1E_BIT = 20;
	localparam int LOCK_BK1P_BIT = 21;
	localparam int ENC_ARR_LSB = 0;

	// CMD word with sw_update in bit 0
	typedef struct packed {
		logic enc_clr;
		logic gen_clr;
		logic sw_update;
	} tim_cmd_t;

endpackage

`default_nettype wire

// File: verilog/tim_cfg_pkg.sv
//============================
// timer side configuration types
// generator base, generator protected and encoder
// payloads with their reset values
//============================
`default_nettype none

`include "tim_settings.svh"

package tim_cfg_pkg;

	typedef logic [`TIM_CNT_W-1:0] cnt_t;
	typedef logic [`TIM_ENC_W-1:0] enc_arr_t;
	typedef logic [`TIM_DTG_W-1:0] dtg_t;
	typedef logic [3:0] oc_mode_t;

	// commit on any update event
	typedef struct packed {
		cnt_t psc;
		cnt_t arr;
		cnt_t cc1;
		oc_mode_t oc1m;
	} gen_base_t;

	// commit only while the generator is idle
	typedef struct packed {
		dtg_t dtg;
		logic cc1e;
		logic cc1p;
		logic moe1;
		logic bk1e;
		logic bk1p;
	} gen_lock_t;

	typedef struct packed {
		enc_arr_t arr;
	} enc_cfg_t;

	localparam gen_base_t GEN_BASE_RST = '{
		psc: cnt_t'(`TIM_RST_PSC),
		arr: cnt_t'(`TIM_RST_ARR),
		cc1: '0,
		oc1m: '0
	};

	localparam gen_lock_t GEN_LOCK_RST = '{
		dtg: dtg_t'(`TIM_RST_DTG),
		default: 1'b0
	};

	localparam enc_cfg_t ENC_CFG_RST = '{arr: enc_arr_t'(`TIM_RST_ENC_ARR)};

endpackage

`default_nettype wire

// File: verilog/tim_shadow_if.sv
//============================
// shadow configuration and command toggles from the
// register stage on reg_clk to the commit stage on pe_clk
//============================
`default_nettype none

interface tim_shadow_if;

	import tim_cfg_pkg::*;

	gen_base_t gen_base;
	gen_lock_t gen_lock;
	enc_cfg_t enc;

	// level, synchronized on the commit side
	logic hw_update_en;

	// each flips once per command
	logic sw_update_tgl;
	logic gen_clr_tgl;
	logic enc_clr_tgl;

	modport regs (
		output gen_base, gen_lock, enc, hw_update_en,
		output sw_update_tgl, gen_clr_tgl, enc_clr_tgl
	);

	modport commit (
		input gen_base, gen_lock, enc, hw_update_en,
		input sw_update_tgl, gen_clr_tgl, enc_clr_tgl
	);

endinterface

`default_nettype wire

// File: verilog/toggle_pulse_sync.sv
//============================
// toggle to pulse crossing into pe_clk
// one pulse of one cycle per change of tgl
//============================
`default_nettype none

module toggle_pulse_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic pe_clk,
	input  logic pe_rstn,
	input  logic tgl,
	output logic pulse
);

	logic [SYNC_STAGES-1:0] sync_q;
	logic hist_q;

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
		begin
			sync_q <= '0;
			hist_q <= 1'b0;
		end
		else
		begin
			// first flop may go metastable
			sync_q <= {sync_q[SYNC_STAGES-2:0], tgl};
			hist_q <= sync_q[SYNC_STAGES-1];
		end
	end

	// edge of the settled toggle
	assign pulse = sync_q[SYNC_STAGES-1] ^ hist_q;

endmodule

`default_nettype wire

// File: verilog/shadow_bank.sv
//============================
// active copy of one configuration payload
// reloads from the shadow on the edge after load
//============================
`default_nettype none

module shadow_bank #(
	parameter type payload_t = logic [7:0],
	parameter payload_t RST_VAL = payload_t'(0)
) (
	input  logic     pe_clk,
	input  logic     pe_rstn,
	input  logic     load,
	input  payload_t shadow,
	output payload_t active
);

	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			active <= RST_VAL;
		else if (load)
			active <= shadow;
	end

endmodule

`default_nettype wire

// File: verilog/tim_apb_regs.sv
//============================
// APB slave on reg_clk with zero-wait transfers
// holds the shadow fields and enable levels, and
// flips one toggle per command bit written as 1
//============================
`default_nettype none

`include "tim_settings.svh"

module tim_apb_regs (
	input  logic                   reg_clk,
	input  logic                   reg_rstn,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`TIM_DATA_W-1:0] paddr,
	input  logic [`TIM_DATA_W-1:0] pwdata,
	output logic [`TIM_DATA_W-1:0] prdata,
	output logic                   gen_enable,
	output logic                   enc_enable,
	tim_shadow_if.regs             shd
);

	import tim_apb_pkg::*;
	import tim_cfg_pkg::*;

	logic wr_en;
	tim_cmd_t cmd_wr;

	// access phase of a write
	assign wr_en = psel & penable & pwrite;
	assign cmd_wr = tim_cmd_t'(pwdata[$bits(tim_cmd_t)-1:0]);

	//============================
	// register writes
	//============================
	always_ff @(posedge reg_clk or negedge reg_rstn)
	begin
		if (!reg_rstn)
		begin
			gen_enable <= 1'b0;
			enc_enable <= 1'b0;
			shd.hw_update_en <= 1'b0;
			shd.gen_base <= GEN_BASE_RST;
			shd.gen_lock <= GEN_LOCK_RST;
			shd.enc <= ENC_CFG_RST;
			shd.sw_update_tgl <= 1'b0;
			shd.gen_clr_tgl <= 1'b0;
			shd.enc_clr_tgl <= 1'b0;
		end
		else if (wr_en)
		begin
			case (paddr)
				TIM_OFS_CTRL:
				begin
					gen_enable <= pwdata[CTRL_GEN_EN_BIT];
					enc_enable <= pwdata[CTRL_ENC_EN_BIT];
					shd.hw_update_en <= pwdata[CTRL_HW_UPD_BIT];
				end
				TIM_OFS_CMD:
				begin
					if (cmd_wr.sw_update)
						shd.sw_update_tgl <= ~shd.sw_update_tgl;
					if (cmd_wr.gen_clr)
						shd.gen_clr_tgl <= ~shd.gen_clr_tgl;
					if (cmd_wr.enc_clr)
						shd.enc_clr_tgl <= ~shd.enc_clr_tgl;
				end
				TIM_OFS_GEN_TB:
				begin
					shd.gen_base.psc <= pwdata[GEN_TB_PSC_LSB +: `TIM_CNT_W];
					shd.gen_base.arr <= pwdata[GEN_TB_ARR_LSB +: `TIM_CNT_W];
				end
				TIM_OFS_GEN_CC1:
				begin
					shd.gen_base.cc1 <= pwdata[GEN_CC1_LSB +: `TIM_CNT_W];
					shd.gen_base.oc1m <= pwdata[GEN_OC1M_LSB +: $bits(oc_mode_t)];
				end
				TIM_OFS_GEN_LOCK:
				begin
					shd.gen_lock.dtg <= pwdata[LOCK_DTG_LSB +: `TIM_DTG_W];
					shd.gen_lock.cc1e <= pwdata[LOCK_CC1E_BIT];
					shd.gen_lock.cc1p <= pwdata[LOCK_CC1P_BIT];
					shd.gen_lock.moe1 <= pwdata[LOCK_MOE1_BIT];
					shd.gen_lock.bk1e <= pwdata[LOCK_BK1E_BIT];
					shd.gen_lock.bk1p <= pwdata[LOCK_BK1P_BIT];
				end
				TIM_OFS_ENC:
				begin
					shd.enc.arr <= pwdata[ENC_ARR_LSB +: `TIM_ENC_W];
				end
				default:
				begin
				end
			endcase
		end
	end

	//============================
	// read-back
	//============================
	always_comb
	begin
		prdata = '0;
		if (psel)
		begin
			case (paddr)
				TIM_OFS_CTRL:
				begin
					prdata[CTRL_GEN_EN_BIT] = gen_enable;
					prdata[CTRL_ENC_EN_BIT] = enc_enable;
					prdata[CTRL_HW_UPD_BIT] = shd.hw_update_en;
				end
				TIM_OFS_GEN_TB:
				begin
					prdata[GEN_TB_PSC_LSB +: `TIM_CNT_W] = shd.gen_base.psc;
					prdata[GEN_TB_ARR_LSB +: `TIM_CNT_W] = shd.gen_base.arr;
				end
				TIM_OFS_GEN_CC1:
				begin
					prdata[GEN_CC1_LSB +: `TIM_CNT_W] = shd.gen_base.cc1;
					prdata[GEN_OC1M_LSB +: $bits(oc_mode_t)] = shd.gen_base.oc1m;
				end
				TIM_OFS_GEN_LOCK:
				begin
					prdata[LOCK_DTG_LSB +: `TIM_DTG_W] = shd.gen_lock.dtg;
					prdata[LOCK_CC1E_BIT] = shd.gen_lock.cc1e;
					prdata[LOCK_CC1P_BIT] = shd.gen_lock.cc1p;
					prdata[LOCK_MOE1_BIT] = shd.gen_lock.moe1;
					prdata[LOCK_BK1E_BIT] = shd.gen_lock.bk1e;
					prdata[LOCK_BK1P_BIT] = shd.gen_lock.bk1p;
				end
				TIM_OFS_ENC:
				begin
					prdata[ENC_ARR_LSB +: `TIM_ENC_W] = shd.enc.arr;
				end
				// CMD is write-only
				default:
				begin
					prdata = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/tim_cfg_commit.sv
//============================
// pe_clk commit stage
// crosses the commands and loads the active banks
//============================
`default_nettype none

`include "tim_settings.svh"

module tim_cfg_commit (
	input  logic                  pe_clk,
	input  logic                  pe_rstn,
	input  logic                  gen_hw_update,
	input  logic                  enc_hw_update,
	input  logic                  gen_running,
	tim_shadow_if.commit          shd,
	output logic                  gen_logic_clr,
	output logic                  enc_logic_clr,
	output tim_cfg_pkg::gen_base_t gen_base,
	output tim_cfg_pkg::gen_lock_t gen_lock,
	output tim_cfg_pkg::enc_cfg_t  enc
);

	import tim_cfg_pkg::*;

	logic [`TIM_SYNC_STAGES-1:0] hw_en_sync;
	logic hw_en;
	logic sw_update;
	logic gen_base_load;
	logic gen_lock_load;
	logic enc_load;

	//============================
	// event crossing
	//============================
	always_ff @(posedge pe_clk or negedge pe_rstn)
	begin
		if (!pe_rstn)
			hw_en_sync <= '0;
		else
			hw_en_sync <= {hw_en_sync[`TIM_SYNC_STAGES-2:0], shd.hw_update_en};
	end

	assign hw_en = hw_en_sync[`TIM_SYNC_STAGES-1];

	toggle_pulse_sync #(.SYNC_STAGES(`TIM_SYNC_STAGES)) u_sw_update_sync (
		.pe_clk  (pe_clk),
		.pe_rstn (pe_rstn),
		.tgl     (shd.sw_update_tgl),
		.pulse   (sw_update)
	);

	toggle_pulse_sync #(.SYNC_STAGES(`TIM_SYNC_STAGES)) u_gen_clr_sync (
		.pe_clk  (pe_clk),
		.pe_rstn (pe_rstn),
		.tgl     (shd.gen_clr_tgl),
		.pulse   (gen_logic_clr)
	);

	toggle_pulse_sync #(.SYNC_STAGES(`TIM_SYNC_STAGES)) u_enc_clr_sync (
		.pe_clk  (pe_clk),
		.pe_rstn (pe_rstn),
		.tgl     (shd.enc_clr_tgl),
		.pulse   (enc_logic_clr)
	);

	//============================
	// commit
	//============================
	assign gen_base_load = sw_update | (gen_hw_update & hw_en);
	assign enc_load = sw_update | (enc_hw_update & hw_en);
	// protected fields never change under a running generator
	assign gen_lock_load = sw_update & ~gen_running;

	shadow_bank #(.payload_t(gen_base_t), .RST_VAL(GEN_BASE_RST)) u_gen_base_bank (
		.pe_clk  (pe_clk),
		.pe_rstn (pe_rstn),
		.load    (gen_base_load),
		.shadow  (shd.gen_base),
		.active  (gen_base)
	);

	shadow_bank #(.payload_t(gen_lock_t), .RST_VAL(GEN_LOCK_RST)) u_gen_lock_bank (
		.pe_clk  (pe_clk),
		.pe_rstn (pe_rstn),
		.load    (gen_lock_load),
		.shadow  (shd.gen_lock),
		.active  (gen_lock)
	);

	shadow_bank #(.payload_t(enc_cfg_t), .RST_VAL(ENC_CFG_RST)) u_enc_bank (
		.pe_clk  (pe_clk),
		.pe_rstn (pe_rstn),
		.load    (enc_load),
		.shadow  (shd.enc),
		.active  (enc)
	);

endmodule

`default_nettype wire

// File: verilog/tim_regs_top.sv
//============================
// timer configuration block top level
// APB register stage on reg_clk, commit stage on pe_clk
// active fields leave as flat ports
//============================
`default_nettype none

`include "tim_settings.svh"

module tim_regs_top (
	input  logic                    reg_clk,
	input  logic                    reg_rstn,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [`TIM_DATA_W-1:0]  paddr,
	input  logic [`TIM_DATA_W-1:0]  pwdata,
	output logic [`TIM_DATA_W-1:0]  prdata,
	input  logic                    pe_clk,
	input  logic                    pe_rstn,
	input  logic                    gen_hw_update,
	input  logic                    enc_hw_update,
	input  logic                    gen_running,
	output logic                    gen_enable,
	output logic                    enc_enable,
	output logic                    gen_logic_clr,
	output logic                    enc_logic_clr,
	output tim_cfg_pkg::cnt_t       gen_psc,
	output tim_cfg_pkg::cnt_t       gen_arr,
	output tim_cfg_pkg::cnt_t       gen_cc1,
	output tim_cfg_pkg::oc_mode_t   gen_oc1m,
	output tim_cfg_pkg::dtg_t       gen_dtg,
	output logic                    gen_cc1e,
	output logic                    gen_cc1p,
	output logic                    gen_moe1,
	output logic                    gen_bk1e,
	output logic                    gen_bk1p,
	output tim_cfg_pkg::enc_arr_t   enc_arr
);

	import tim_cfg_pkg::*;

	gen_base_t gen_base;
	gen_lock_t gen_lock;
	enc_cfg_t enc;

	tim_shadow_if shd_if ();

	tim_apb_regs u_apb_regs (
		.reg_clk    (reg_clk),
		.reg_rstn   (reg_rstn),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.gen_enable (gen_enable),
		.enc_enable (enc_enable),
		.shd        (shd_if.regs)
	);

	tim_cfg_commit u_cfg_commit (
		.pe_clk        (pe_clk),
		.pe_rstn       (pe_rstn),
		.gen_hw_update (gen_hw_update),
		.enc_hw_update (enc_hw_update),
		.gen_running   (gen_running),
		.shd           (shd_if.commit),
		.gen_logic_clr (gen_logic_clr),
		.enc_logic_clr (enc_logic_clr),
		.gen_base      (gen_base),
		.gen_lock      (gen_lock),
		.enc           (enc)
	);

	// flat active fields for the engines
	assign gen_psc = gen_base.psc;
	assign gen_arr = gen_base.arr;
	assign gen_cc1 = gen_base.cc1;
	assign gen_oc1m = gen_base.oc1m;
	assign gen_dtg = gen_lock.dtg;
	assign gen_cc1e = gen_lock.cc1e;
	assign gen_cc1p = gen_lock.cc1p;
	assign gen_moe1 = gen_lock.moe1;
	assign gen_bk1e = gen_lock.bk1e;
	assign gen_bk1p = gen_lock.bk1p;
	assign enc_arr = enc.arr;

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
//============================
// testbench clock source
// free running clock, active low reset held for 16 cycles
//============================
`default_nettype none

module tb_clk_gen #(
	parameter real PERIOD_NS = 20.0,
	parameter int RST_CYCLES = 16
) (
	output logic clk,
	output logic rstn
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = ~clk;
	end

	initial
	begin
		rstn = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

// File: tb/tb_tim_regs.sv
//============================
// testbench of the timer configuration block
// APB stimulus on reg_clk, engine strobes on pe_clk,
// expected values kept as register words
//============================
`default_nettype none

module tb_tim_regs;

	timeunit 1ns;
	timeprecision 1ps;

	import tim_apb_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int TEST_BUDGET_NS = 2000;
	localparam int COMMIT_WAIT = 8;
	localparam int CMD_GAP = 12;
	localparam logic [31:0] OFS_UNUSED = 32'h18;

	// implemented bits per register
	localparam logic [31:0] CTRL_MASK = 32'h0000_0007;
	localparam logic [31:0] TB_MASK = 32'hffff_ffff;
	localparam logic [31:0] CC1_MASK = 32'h000f_ffff;
	localparam logic [31:0] LOCK_MASK = 32'h0037_03ff;
	localparam logic [31:0] ENC_MASK = 32'h00ff_ffff;

	localparam logic [31:0] TB_RST = 32'h0032_0002;
	localparam logic [31:0] CC1_RST = 32'h0000_0000;
	localparam logic [31:0] LOCK_RST = 32'h0000_0005;
	localparam logic [31:0] ENC_RST = 32'h0000_8000;

	logic pe_clk;
	logic pe_rstn;
	logic reg_clk;
	logic reg_rstn;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic gen_hw_update;
	logic enc_hw_update;
	logic gen_running;
	logic gen_enable;
	logic enc_enable;
	logic gen_logic_clr;
	logic enc_logic_clr;
	logic [15:0] gen_psc;
	logic [15:0] gen_arr;
	logic [15:0] gen_cc1;
	logic [3:0] gen_oc1m;
	logic [9:0] gen_dtg;
	logic gen_cc1e;
	logic gen_cc1p;
	logic gen_moe1;
	logic gen_bk1e;
	logic gen_bk1p;
	logic [23:0] enc_arr;

	// active outputs folded back into register layout
	logic [31:0] act_tb;
	logic [31:0] act_cc1;
	logic [31:0] act_lock;
	logic [31:0] act_enc;

	// shadow and active model
	logic [31:0] shd_ctrl = 32'h0;
	logic [31:0] shd_tb = TB_RST;
	logic [31:0] shd_cc1 = CC1_RST;
	logic [31:0] shd_lock = LOCK_RST;
	logic [31:0] shd_enc = ENC_RST;
	logic [31:0] exp_tb = TB_RST;
	logic [31:0] exp_cc1 = CC1_RST;
	logic [31:0] exp_lock = LOCK_RST;
	logic [31:0] exp_enc = ENC_RST;

	integer seed = 32'h5aef_e121;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int test_start_errs = 0;
	string test_name = "";

	assign act_tb = {gen_arr, gen_psc};
	assign act_cc1 = {12'h000, gen_oc1m, gen_cc1};
	assign act_lock = {10'h000, gen_bk1p, gen_bk1e, 1'b0, gen_moe1, gen_cc1p, gen_cc1e,
		6'h00, gen_dtg};
	assign act_enc = {8'h00, enc_arr};

	tb_clk_gen #(.PERIOD_NS(20.0)) pe_clk_gen (.clk(pe_clk), .rstn(pe_rstn));
	tb_clk_gen #(.PERIOD_NS(26.0)) reg_clk_gen (.clk(reg_clk), .rstn(reg_rstn));

	tim_regs_top UUT (
		.reg_clk       (reg_clk),
		.reg_rstn      (reg_rstn),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pe_clk        (pe_clk),
		.pe_rstn       (pe_rstn),
		.gen_hw_update (gen_hw_update),
		.enc_hw_update (enc_hw_update),
		.gen_running   (gen_running),
		.gen_enable    (gen_enable),
		.enc_enable    (enc_enable),
		.gen_logic_clr (gen_logic_clr),
		.enc_logic_clr (enc_logic_clr),
		.gen_psc       (gen_psc),
		.gen_arr       (gen_arr),
		.gen_cc1       (gen_cc1),
		.gen_oc1m      (gen_oc1m),
		.gen_dtg       (gen_dtg),
		.gen_cc1e      (gen_cc1e),
		.gen_cc1p      (gen_cc1p),
		.gen_moe1      (gen_moe1),
		.gen_bk1e      (gen_bk1e),
		.gen_bk1p      (gen_bk1p),
		.enc_arr       (enc_arr)
	);

	//============================
	// concurrent checks
	//============================
	gen_clr_width: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		gen_logic_clr |=> !gen_logic_clr)
	else
	begin
		$display("gen_logic_clr stayed high for more than one pe_clk cycle");
		errors++;
	end

	enc_clr_width: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		enc_logic_clr |=> !enc_logic_clr)
	else
	begin
		$display("enc_logic_clr stayed high for more than one pe_clk cycle");
		errors++;
	end

	clr_exclusive: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		!(gen_logic_clr && enc_logic_clr))
	else
	begin
		$display("both logic clear pulses were high in the same cycle");
		errors++;
	end

	// protected fields frozen under a running generator
	lock_hold: assert property (@(posedge pe_clk) disable iff (!pe_rstn)
		gen_running |=> $stable(act_lock))
	else
	begin
		$display("protected fields changed while the generator was running");
		errors++;
	end

	//============================
	// helpers
	//============================
	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
		@(posedge reg_clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge reg_clk);
		penable <= 1'b1;
		// register takes the value on this edge
		@(posedge reg_clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
		@(posedge reg_clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge reg_clk);
		penable <= 1'b1;
		@(posedge reg_clk);
		data = prdata;
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic check_word(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			$display("[ERROR] %s %s: expected 0x%08h, actual 0x%08h",
				test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic read_check(input logic [31:0] addr, input logic [31:0] exp,
		input string what);
		logic [31:0] data;
		apb_read(addr, data);
		check_word({what, " read"}, exp, data);
	endtask

	task automatic read_all_regs();
		read_check(TIM_OFS_CTRL, shd_ctrl, "CTRL");
		read_check(TIM_OFS_CMD, 32'h0, "CMD");
		read_check(TIM_OFS_GEN_TB, shd_tb, "GEN_TB");
		read_check(TIM_OFS_GEN_CC1, shd_cc1, "GEN_CC1");
		read_check(TIM_OFS_GEN_LOCK, shd_lock, "GEN_LOCK");
		read_check(TIM_OFS_ENC, shd_enc, "ENC");
		read_check(OFS_UNUSED, 32'h0, "unused offset");
	endtask

	task automatic check_active(input string what);
		check_word({what, " active tb"}, exp_tb, act_tb);
		check_word({what, " active cc1"}, exp_cc1, act_cc1);
		check_word({what, " active lock"}, exp_lock, act_lock);
		check_word({what, " active enc"}, exp_enc, act_enc);
	endtask

	task automatic write_random_shadow();
		logic [31:0] data;
		data = $random(seed);
		apb_write(TIM_OFS_GEN_TB, data);
		shd_tb = data & TB_MASK;
		data = $random(seed);
		apb_write(TIM_OFS_GEN_CC1, data);
		shd_cc1 = data & CC1_MASK;
		data = $random(seed);
		apb_write(TIM_OFS_GEN_LOCK, data);
		shd_lock = data & LOCK_MASK;
		data = $random(seed);
		apb_write(TIM_OFS_ENC, data);
		shd_enc = data & ENC_MASK;
	endtask

	task automatic send_sw_update();
		tim_cmd_t cmd;
		cmd = '0;
		cmd.sw_update = 1'b1;
		apb_write(TIM_OFS_CMD, {29'h0, cmd});
	endtask

	// base and encoder banks load together with any sw_update
	task automatic wait_commit();
		bit hit;
		int cyc;
		hit = 1'b0;
		for (cyc = 0; cyc < COMMIT_WAIT && !hit; cyc++)
		begin
			@(negedge pe_clk);
			hit = (act_tb === shd_tb) && (act_cc1 === shd_cc1) && (act_enc === shd_enc);
		end
		checks++;
		assert (hit)
		else
		begin
			$display("%s: base and encoder fields did not commit within %0d pe_clk cycles",
				test_name, COMMIT_WAIT);
			errors++;
		end
	endtask

	task automatic strobe_and_check(input bit gen, input bit enc, input bit expect_load);
		@(posedge pe_clk);
		gen_hw_update <= gen;
		enc_hw_update <= enc;
		@(negedge pe_clk);
		check_active("before strobe");
		@(posedge pe_clk);
		gen_hw_update <= 1'b0;
		enc_hw_update <= 1'b0;
		if (expect_load && gen)
		begin
			exp_tb = shd_tb;
			exp_cc1 = shd_cc1;
		end
		if (expect_load && enc)
			exp_enc = shd_enc;
		@(negedge pe_clk);
		check_active("after strobe");
	endtask

	task automatic check_clear_pulse(input bit gen_side);
		tim_cmd_t cmd;
		int own_cnt;
		int other_cnt;
		int cyc;
		bit early;
		logic own;
		logic other;
		cmd = '0;
		cmd.gen_clr = gen_side;
		cmd.enc_clr = !gen_side;
		own_cnt = 0;
		other_cnt = 0;
		early = 1'b0;
		apb_write(TIM_OFS_CMD, {29'h0, cmd});
		for (cyc = 0; cyc < COMMIT_WAIT + CMD_GAP; cyc++)
		begin
			@(negedge pe_clk);
			own = gen_side ? gen_logic_clr : enc_logic_clr;
			other = gen_side ? enc_logic_clr : gen_logic_clr;
			if (own)
			begin
				own_cnt++;
				if (cyc < COMMIT_WAIT)
					early = 1'b1;
			end
			if (other)
				other_cnt++;
		end
		checks++;
		assert (early)
		else
		begin
			$display("%s: no clear pulse within %0d pe_clk cycles", test_name, COMMIT_WAIT);
			errors++;
		end
		check_word(gen_side ? "gen clear pulses" : "enc clear pulses", 32'd1, 32'(own_cnt));
		check_word(gen_side ? "enc stray pulses" : "gen stray pulses", 32'd0, 32'(other_cnt));
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errs = errors;
	endtask

	task automatic end_test();
		tests_run++;
		$display("test %0d %s: %s", tests_run, test_name,
			(errors == test_start_errs) ? "ok" : "errors found");
	endtask

	//============================
	// stimulus
	//============================
	initial
	begin
		logic [31:0] data;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		gen_hw_update = 1'b0;
		enc_hw_update = 1'b0;
		gen_running = 1'b0;
		wait (pe_rstn === 1'b1 && reg_rstn === 1'b1);
		@(posedge reg_clk);

		begin_test("reset_values");
		check_word("gen_enable", 32'h0, {31'h0, gen_enable});
		check_word("enc_enable", 32'h0, {31'h0, enc_enable});
		check_word("gen_logic_clr", 32'h0, {31'h0, gen_logic_clr});
		check_word("enc_logic_clr", 32'h0, {31'h0, enc_logic_clr});
		check_active("reset");
		read_all_regs();
		end_test();

		begin_test("register_access");
		data = $random(seed);
		apb_write(TIM_OFS_CTRL, data);
		shd_ctrl = data & CTRL_MASK;
		write_random_shadow();
		apb_write(OFS_UNUSED, $random(seed));
		read_all_regs();
		check_word("gen_enable", {31'h0, shd_ctrl[0]}, {31'h0, gen_enable});
		check_word("enc_enable", {31'h0, shd_ctrl[1]}, {31'h0, enc_enable});
		repeat (COMMIT_WAIT) @(negedge pe_clk);
		check_active("no commit");
		end_test();

		begin_test("sw_update");
		send_sw_update();
		wait_commit();
		exp_tb = shd_tb;
		exp_cc1 = shd_cc1;
		exp_lock = shd_lock;
		exp_enc = shd_enc;
		check_active("committed");
		repeat (CMD_GAP) @(negedge pe_clk);
		end_test();

		begin_test("hw_update");
		apb_write(TIM_OFS_CTRL, 32'h4);
		shd_ctrl = 32'h4;
		// let hw_update_en settle in pe_clk
		repeat (CMD_GAP) @(negedge pe_clk);
		write_random_shadow();
		strobe_and_check(1'b1, 1'b0, 1'b1);
		// fresh shadow so a base load on the encoder strobe shows
		write_random_shadow();
		strobe_and_check(1'b0, 1'b1, 1'b1);
		apb_write(TIM_OFS_CTRL, 32'h0);
		shd_ctrl = 32'h0;
		repeat (CMD_GAP) @(negedge pe_clk);
		write_random_shadow();
		strobe_and_check(1'b1, 1'b1, 1'b0);
		end_test();

		begin_test("locked_update");
		@(posedge pe_clk);
		gen_running <= 1'b1;
		write_random_shadow();
		send_sw_update();
		wait_commit();
		exp_tb = shd_tb;
		exp_cc1 = shd_cc1;
		exp_enc = shd_enc;
		check_active("running");
		repeat (CMD_GAP) @(negedge pe_clk);
		@(posedge pe_clk);
		gen_running <= 1'b0;
		end_test();

		begin_test("logic_clear");
		check_clear_pulse(1'b1);
		check_clear_pulse(1'b0);
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(NUM_TESTS * TEST_BUDGET_NS);
		$display("timeout: tests did not finish within %0d ns", NUM_TESTS * TEST_BUDGET_NS);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
verilog/tim_apb_pkg.sv
verilog/tim_cfg_pkg.sv
verilog/tim_shadow_if.sv
verilog/toggle_pulse_sync.sv
verilog/shadow_bank.sv
verilog/tim_apb_regs.sv
verilog/tim_cfg_commit.sv
verilog/tim_regs_top.sv
tb/tb_clk_gen.sv
tb/tb_tim_regs.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the timer register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f files.f --top-module tb_tim_regs -o tb_tim_regs
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

sim_out=$(./obj_dir/tb_tim_regs)
status=$?
echo "$sim_out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

echo "$sim_out" | grep -q "^TB PASSED$"
status=$?
if [ $status -ne 0 ]; then
	echo "pass message not found in simulation output"
	exit 1
fi

exit 0
